//--- hdl/board_pkg.sv
`default_nettype none

package board_pkg;

  //////////////////////////////////////////////////
  // Bus and board widths
  //////////////////////////////////////////////////

  // APB byte address and data word
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Boot switch code and fan duty level
  typedef logic [1:0]  boot_mode_t;
  typedef logic [3:0]  fan_level_t;

  // RTC half period and divider counter
  typedef logic [15:0] rtc_count_t;

  //////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////

  // SoC reset hold after the last cause goes away
  localparam int unsigned RST_HOLD_CYCLES = 8;

  // Fan PWM: FAN_PRESCALE clocks per step, FAN_STEPS steps per period
  localparam int unsigned FAN_PRESCALE    = 4;
  localparam int unsigned FAN_STEPS       = 16;

  // Counter widths derived from the timing above
  typedef logic [$clog2(RST_HOLD_CYCLES)-1:0] rst_cnt_t;
  typedef logic [$clog2(FAN_PRESCALE)-1:0]    fan_presc_t;

endpackage

`default_nettype wire

//--- hdl/board_regmap_pkg.sv
`default_nettype none

package board_regmap_pkg;

  //////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////

  localparam board_pkg::apb_addr_t CTRL_OFFS     = 12'h000;
  localparam board_pkg::apb_addr_t RTC_HALF_OFFS = 12'h004;
  localparam board_pkg::apb_addr_t FAN_OFFS      = 12'h008;
  localparam board_pkg::apb_addr_t STATUS_OFFS   = 12'h00C;

  // CTRL fields
  localparam int unsigned CTRL_SOFT_RST_BIT    = 0;
  localparam int unsigned CTRL_BOOT_OVR_EN_BIT = 1;
  localparam int unsigned CTRL_BOOT_OVR_LSB    = 2;

  // FAN fields
  localparam int unsigned FAN_LVL_LSB          = 0;
  localparam int unsigned FAN_OVR_EN_BIT       = 4;

  // STATUS fields
  localparam int unsigned STATUS_BOOT_LSB      = 0;
  localparam int unsigned STATUS_FAN_LSB       = 4;

  // Reset and error values
  localparam board_pkg::rtc_count_t RTC_HALF_RESET = 16'd24;
  localparam board_pkg::apb_data_t  ERR_READ_VALUE = 32'hBADC_AB1E;

endpackage

`default_nettype wire

//--- hdl/board_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_regs (
  input  wire                       soc_clk,
  input  wire                       rst_n,
  // APB slave
  input  wire board_pkg::apb_addr_t paddr_i,
  input  wire                       psel_i,
  input  wire                       penable_i,
  input  wire                       pwrite_i,
  input  wire board_pkg::apb_data_t pwdata_i,
  output board_pkg::apb_data_t      prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // Board switches
  input  wire board_pkg::boot_mode_t boot_mode_i,
  input  wire board_pkg::fan_level_t fan_sw_i,
  // Towards the datapath modules
  output logic                      soft_rst_req_o,
  output board_pkg::rtc_count_t     rtc_half_o,
  output board_pkg::fan_level_t     fan_level_o,
  output board_pkg::boot_mode_t     boot_mode_o
);

  import board_pkg::*;
  import board_regmap_pkg::*;

  logic       apb_setup;
  logic       apb_wr;
  logic       sel_ctrl;
  logic       sel_rtc;
  logic       sel_fan;
  logic       sel_status;
  logic       addr_err;
  apb_data_t  rd_data;
  apb_data_t  status_word;

  // Configuration registers
  logic       soft_rst_q;
  logic       boot_ovr_en_q;
  boot_mode_t boot_ovr_val_q;
  rtc_count_t rtc_half_q;
  fan_level_t fan_ovr_lvl_q;
  logic       fan_ovr_en_q;

  // Registered bus response
  logic       pready_q;
  logic       pslverr_q;
  apb_data_t  prdata_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign apb_setup  = psel_i & ~penable_i;
  assign apb_wr     = psel_i & penable_i & pwrite_i;

  assign sel_ctrl   = (paddr_i == CTRL_OFFS);
  assign sel_rtc    = (paddr_i == RTC_HALF_OFFS);
  assign sel_fan    = (paddr_i == FAN_OFFS);
  assign sel_status = (paddr_i == STATUS_OFFS);

  // Unmapped address, or a write to the read-only STATUS
  assign addr_err = ~(sel_ctrl | sel_rtc | sel_fan | sel_status) | (sel_status & pwrite_i);

  //////////////////////////////////////////////////
  // Effective boot mode and fan level
  //////////////////////////////////////////////////

  assign boot_mode_o = boot_ovr_en_q ? boot_ovr_val_q : boot_mode_i;
  assign fan_level_o = fan_ovr_en_q ? fan_ovr_lvl_q : fan_sw_i;

  always_comb begin
    status_word = '0;
    status_word[STATUS_BOOT_LSB +: $bits(boot_mode_t)] = boot_mode_o;
    status_word[STATUS_FAN_LSB +: $bits(fan_level_t)]  = fan_level_o;
  end

  // Read mux, unmapped reads return the error pattern
  always_comb begin
    rd_data = ERR_READ_VALUE;
    if (sel_ctrl) begin
      rd_data = '0;
      rd_data[CTRL_SOFT_RST_BIT]    = soft_rst_q;
      rd_data[CTRL_BOOT_OVR_EN_BIT] = boot_ovr_en_q;
      rd_data[CTRL_BOOT_OVR_LSB +: $bits(boot_mode_t)] = boot_ovr_val_q;
    end else if (sel_rtc) begin
      rd_data = apb_data_t'(rtc_half_q);
    end else if (sel_fan) begin
      rd_data = '0;
      rd_data[FAN_LVL_LSB +: $bits(fan_level_t)] = fan_ovr_lvl_q;
      rd_data[FAN_OVR_EN_BIT] = fan_ovr_en_q;
    end else if (sel_status) begin
      rd_data = status_word;
    end
  end

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      soft_rst_q     <= 1'b0;
      boot_ovr_en_q  <= 1'b0;
      boot_ovr_val_q <= '0;
      rtc_half_q     <= RTC_HALF_RESET;
      fan_ovr_lvl_q  <= '0;
      fan_ovr_en_q   <= 1'b0;
    end else if (apb_wr) begin
      if (sel_ctrl) begin
        soft_rst_q     <= pwdata_i[CTRL_SOFT_RST_BIT];
        boot_ovr_en_q  <= pwdata_i[CTRL_BOOT_OVR_EN_BIT];
        boot_ovr_val_q <= pwdata_i[CTRL_BOOT_OVR_LSB +: $bits(boot_mode_t)];
      end
      if (sel_rtc) begin
        rtc_half_q <= pwdata_i[$bits(rtc_count_t)-1:0];
      end
      if (sel_fan) begin
        fan_ovr_lvl_q <= pwdata_i[FAN_LVL_LSB +: $bits(fan_level_t)];
        fan_ovr_en_q  <= pwdata_i[FAN_OVR_EN_BIT];
      end
    end
  end

  //////////////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////////////

  // Prepared in the setup phase so it is valid for the whole access phase
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= apb_setup;
      pslverr_q <= apb_setup & addr_err;
    end
  end

  always_ff @(posedge soc_clk) begin
    if (apb_setup) begin
      prdata_q <= pwrite_i ? '0 : rd_data;
    end
  end

  assign pready_o       = pready_q;
  assign pslverr_o      = pslverr_q;
  assign prdata_o       = prdata_q;
  assign soft_rst_req_o = soft_rst_q;
  assign rtc_half_o     = rtc_half_q;

  // Ready is only ever given in an access phase
  a_pready_in_access: assert property (
    @(posedge soc_clk) disable iff (!rst_n) pready_o |-> (psel_i && penable_i)
  );

endmodule

`default_nettype wire

//--- hdl/soc_reset_seq.sv
`timescale 1ns/1ns
`default_nettype none

module soc_reset_seq (
  input  wire  soc_clk,
  input  wire  rst_n,
  input  wire  soft_rst_req_i,
  output logic soc_rst_n_o
);

  import board_pkg::*;

  typedef enum logic {
    RST_HOLD,
    RST_RUN
  } rst_state_e;

  rst_state_e state_q;
  rst_cnt_t   hold_cnt_q;
  logic       hold_done;

  // Last cycle of the hold window
  assign hold_done = (hold_cnt_q == rst_cnt_t'(RST_HOLD_CYCLES - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= RST_HOLD;
      hold_cnt_q <= '0;
    end else if (soft_rst_req_i) begin
      // Any request restarts the hold window
      state_q    <= RST_HOLD;
      hold_cnt_q <= '0;
    end else begin
      case (state_q)
        RST_HOLD: begin
          if (hold_done) begin
            state_q <= RST_RUN;
          end else begin
            hold_cnt_q <= hold_cnt_q + 1'b1;
          end
        end
        RST_RUN: begin
          state_q <= RST_RUN;
        end
        default: begin
          state_q <= RST_HOLD;
        end
      endcase
    end
  end

  // SoC reset released only in RST_RUN
  assign soc_rst_n_o = (state_q == RST_RUN);

  a_soft_rst_holds_soc: assert property (
    @(posedge soc_clk) disable iff (!rst_n) soft_rst_req_i |=> !soc_rst_n_o
  );

endmodule

`default_nettype wire

//--- hdl/rtc_divider.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_divider (
  input  wire                        soc_clk,
  input  wire                        rst_n,
  input  wire board_pkg::rtc_count_t rtc_half_i,
  output logic                       rtc_o
);

  import board_pkg::*;

  rtc_count_t count_q;
  logic       wrap;

  // >= so that lowering the half period never lets the counter run away
  assign wrap = (count_q >= rtc_half_i);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      rtc_o   <= 1'b0;
    end else if (wrap) begin
      count_q <= '0;
      rtc_o   <= ~rtc_o;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // Counter restarts from zero after every toggle
  a_wrap_clears_count: assert property (
    @(posedge soc_clk) disable iff (!rst_n) wrap |=> (count_q == '0)
  );

endmodule

`default_nettype wire

//--- hdl/fan_pwm.sv
`timescale 1ns/1ns
`default_nettype none

module fan_pwm (
  input  wire                        soc_clk,
  input  wire                        rst_n,
  input  wire board_pkg::fan_level_t level_i,
  output logic                       fan_pwm_o
);

  import board_pkg::*;

  fan_presc_t presc_q;
  fan_level_t step_q;
  fan_level_t level_q;
  logic       presc_last;
  logic       period_last;

  //////////////////////////////////////////////////
  // Period counters
  //////////////////////////////////////////////////

  assign presc_last  = (presc_q == fan_presc_t'(FAN_PRESCALE - 1));
  assign period_last = presc_last && (step_q == fan_level_t'(FAN_STEPS - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
      level_q <= '0;
    end else begin
      if (presc_last) begin
        presc_q <= '0;
      end else begin
        presc_q <= presc_q + 1'b1;
      end

      if (period_last) begin
        step_q <= '0;
      end else if (presc_last) begin
        step_q <= step_q + 1'b1;
      end

      // New level only at a period boundary, no shortened pulses
      if (period_last) begin
        level_q <= level_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output
  //////////////////////////////////////////////////

  // High for the first level_q steps, never high for level 0
  assign fan_pwm_o = (step_q < level_q);

endmodule

`default_nettype wire

//--- hdl/board_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_top (
  input  wire                        soc_clk,
  input  wire                        rst_n,
  // APB configuration port
  input  wire board_pkg::apb_addr_t  paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire board_pkg::apb_data_t  pwdata_i,
  output board_pkg::apb_data_t       prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Board pins
  input  wire board_pkg::boot_mode_t boot_mode_i,
  input  wire board_pkg::fan_level_t fan_sw_i,
  output logic                       soc_rst_n_o,
  output board_pkg::boot_mode_t      boot_mode_o,
  output logic                       rtc_o,
  output logic                       fan_pwm_o
);

  logic                  soft_rst_req;
  board_pkg::rtc_count_t rtc_half;
  board_pkg::fan_level_t fan_level;

  //////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////

  board_ctrl_regs i_regs (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .paddr_i        ( paddr_i      ),
    .psel_i         ( psel_i       ),
    .penable_i      ( penable_i    ),
    .pwrite_i       ( pwrite_i     ),
    .pwdata_i       ( pwdata_i     ),
    .prdata_o       ( prdata_o     ),
    .pready_o       ( pready_o     ),
    .pslverr_o      ( pslverr_o    ),
    .boot_mode_i    ( boot_mode_i  ),
    .fan_sw_i       ( fan_sw_i     ),
    .soft_rst_req_o ( soft_rst_req ),
    .rtc_half_o     ( rtc_half     ),
    .fan_level_o    ( fan_level    ),
    .boot_mode_o    ( boot_mode_o  )
  );

  //////////////////////////////////////////////////
  // SoC reset
  //////////////////////////////////////////////////

  soc_reset_seq i_reset_seq (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .soft_rst_req_i ( soft_rst_req ),
    .soc_rst_n_o    ( soc_rst_n_o  )
  );

  //////////////////////////////////////////////////
  // RTC clock and fan
  //////////////////////////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk    ( soc_clk  ),
    .rst_n      ( rst_n    ),
    .rtc_half_i ( rtc_half ),
    .rtc_o      ( rtc_o    )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .level_i   ( fan_level ),
    .fan_pwm_o ( fan_pwm_o )
  );

endmodule

`default_nettype wire

//--- verification/board_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_tb;

  import board_pkg::*;
  import board_regmap_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int NUM_ENTRIES  = 21;
  localparam int FAN_WINDOWS  = 5;
  localparam int PWM_PERIOD   = FAN_PRESCALE * FAN_STEPS;
  // Reset, boot mode and soft reset steps outside the table
  localparam int OTHER_CYCLES = 400;

  typedef struct packed {
    logic      is_read;
    apb_addr_t addr;
    apb_data_t wdata;
    apb_data_t rdata;
    logic      err;
  } access_t;

  logic       soc_clk;
  logic       rst_n;
  apb_addr_t  paddr_i;
  logic       psel_i;
  logic       penable_i;
  logic       pwrite_i;
  apb_data_t  pwdata_i;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  boot_mode_t boot_mode_i;
  fan_level_t fan_sw_i;
  logic       soc_rst_n_o;
  boot_mode_t boot_mode_o;
  logic       rtc_o;
  logic       fan_pwm_o;

  access_t    tbl [NUM_ENTRIES];
  int         n_checks;
  int         n_errors;
  int         n_tests;
  int         errors_at_start;

  board_ctrl_top UUT (.*);

  initial begin
    soc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) soc_clk = ~soc_clk;
  end

  //////////////////////////////////////////////////
  // Checking and reporting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    n_checks++;
    assert (got === exp) else begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
      n_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    n_checks++;
    assert (cond) else begin
      $display("Error: %s", what);
      n_errors++;
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (n_errors == errors_at_start) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, n_errors - errors_at_start);
    end
    errors_at_start = n_errors;
  endtask

  // Expected STATUS word, boot mode in bits 1:0 and fan level in bits 7:4
  function automatic apb_data_t status_value(input boot_mode_t boot, input fan_level_t fan);
    return (apb_data_t'(fan) << 4) | apb_data_t'(boot);
  endfunction

  function automatic int rtc_half_value(input int idx);
    case (idx)
      0:       return 24;
      1:       return 3;
      default: return 0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Bus and pin drivers
  //////////////////////////////////////////////////

  task automatic bus_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    @(posedge soc_clk);
    #1;
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    // Setup phase, no response yet
    @(negedge soc_clk);
    check_value("pready_o (setup phase)", 0, pready_o);
    check_value("pslverr_o (setup phase)", 0, pslverr_o);
    @(posedge soc_clk);
    #1;
    penable_i = 1'b1;
    // Zero wait states, ready in the first access cycle
    @(negedge soc_clk);
    check_true(pready_o, $sformatf("no pready_o in the access phase at 0x%h", addr));
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge soc_clk);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t ignored;
    bus_transfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic set_switches(input boot_mode_t boot, input fan_level_t fan);
    @(posedge soc_clk);
    #1;
    boot_mode_i = boot;
    fan_sw_i    = fan;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic check_reset_values();
    int        cycles;
    apb_data_t rdata;
    logic      err;
    repeat (4) @(posedge soc_clk);
    @(negedge soc_clk);
    check_value("soc_rst_n_o", 0, soc_rst_n_o);
    check_value("pready_o", 0, pready_o);
    check_value("pslverr_o", 0, pslverr_o);
    check_value("rtc_o", 0, rtc_o);
    check_value("fan_pwm_o", 0, fan_pwm_o);
    @(posedge soc_clk);
    #1;
    rst_n  = 1'b1;
    cycles = 0;
    @(negedge soc_clk);
    while (!soc_rst_n_o && cycles < RST_HOLD_CYCLES + 2) begin
      cycles++;
      @(negedge soc_clk);
    end
    check_true(soc_rst_n_o, $sformatf("soc_rst_n_o still low %0d cycles after reset", cycles));
    apb_read(CTRL_OFFS, rdata, err);
    check_value("prdata_o (CTRL)", 0, rdata);
    apb_read(FAN_OFFS, rdata, err);
    check_value("prdata_o (FAN)", 0, rdata);
    apb_read(RTC_HALF_OFFS, rdata, err);
    check_value("prdata_o (RTC_HALF)", 24, rdata);
    apb_read(STATUS_OFFS, rdata, err);
    check_value("prdata_o (STATUS)", status_value(boot_mode_i, fan_sw_i), rdata);
    end_test("reset");
  endtask

  function automatic void load_access_table();
    apb_data_t sw_status;
    sw_status = status_value(boot_mode_i, fan_sw_i);
    // read, address, write data, expected read data, expected pslverr
    tbl[0]  = '{1'b0, CTRL_OFFS,     32'hFFFF_FFFA, 32'h0000_0000, 1'b0};
    tbl[1]  = '{1'b1, CTRL_OFFS,     32'h0000_0000, 32'h0000_000A, 1'b0};
    tbl[2]  = '{1'b0, RTC_HALF_OFFS, 32'hABCD_1234, 32'h0000_0000, 1'b0};
    tbl[3]  = '{1'b1, RTC_HALF_OFFS, 32'h0000_0000, 32'h0000_1234, 1'b0};
    tbl[4]  = '{1'b0, FAN_OFFS,      32'hFFFF_FFF7, 32'h0000_0000, 1'b0};
    tbl[5]  = '{1'b1, FAN_OFFS,      32'h0000_0000, 32'h0000_0017, 1'b0};
    tbl[6]  = '{1'b1, STATUS_OFFS,   32'h0000_0000, 32'h0000_0072, 1'b0};
    tbl[7]  = '{1'b0, STATUS_OFFS,   32'h0000_0000, 32'h0000_0000, 1'b1};
    tbl[8]  = '{1'b1, STATUS_OFFS,   32'h0000_0000, 32'h0000_0072, 1'b0};
    tbl[9]  = '{1'b1, 12'h010,       32'h0000_0000, 32'hBADC_AB1E, 1'b1};
    tbl[10] = '{1'b1, 12'hFFC,       32'h0000_0000, 32'hBADC_AB1E, 1'b1};
    tbl[11] = '{1'b1, 12'h006,       32'h0000_0000, 32'hBADC_AB1E, 1'b1};
    tbl[12] = '{1'b0, 12'h020,       32'h1234_5678, 32'h0000_0000, 1'b1};
    tbl[13] = '{1'b1, CTRL_OFFS,     32'h0000_0000, 32'h0000_000A, 1'b0};
    tbl[14] = '{1'b0, CTRL_OFFS,     32'h0000_0000, 32'h0000_0000, 1'b0};
    tbl[15] = '{1'b1, CTRL_OFFS,     32'h0000_0000, 32'h0000_0000, 1'b0};
    tbl[16] = '{1'b0, FAN_OFFS,      32'h0000_0000, 32'h0000_0000, 1'b0};
    tbl[17] = '{1'b1, FAN_OFFS,      32'h0000_0000, 32'h0000_0000, 1'b0};
    tbl[18] = '{1'b1, STATUS_OFFS,   32'h0000_0000, sw_status,     1'b0};
    tbl[19] = '{1'b0, RTC_HALF_OFFS, 32'h0000_0018, 32'h0000_0000, 1'b0};
    tbl[20] = '{1'b1, RTC_HALF_OFFS, 32'h0000_0000, 32'h0000_0018, 1'b0};
  endfunction

  task automatic run_register_table();
    apb_data_t rdata;
    logic      err;
    load_access_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].is_read) begin
        apb_read(tbl[i].addr, rdata, err);
        check_value($sformatf("prdata_o at 0x%h", tbl[i].addr), tbl[i].rdata, rdata);
      end else begin
        apb_write(tbl[i].addr, tbl[i].wdata, err);
      end
      check_value($sformatf("pslverr_o at 0x%h", tbl[i].addr), tbl[i].err, err);
    end
    end_test("register_table");
  endtask

  task automatic check_boot_mode();
    boot_mode_t sw;
    boot_mode_t ovr;
    logic       err;
    repeat (6) begin
      sw = boot_mode_t'($urandom_range(3));
      set_switches(sw, fan_sw_i);
      @(negedge soc_clk);
      check_value("boot_mode_o", sw, boot_mode_o);
    end
    // Override value in CTRL bits 3:2, enable in bit 1
    for (int v = 0; v < 4; v++) begin
      ovr = boot_mode_t'(v);
      apb_write(CTRL_OFFS, (apb_data_t'(ovr) << 2) | 32'h2, err);
      repeat (3) begin
        set_switches(boot_mode_t'($urandom_range(3)), fan_sw_i);
        @(negedge soc_clk);
        check_value("boot_mode_o", ovr, boot_mode_o);
      end
    end
    apb_write(CTRL_OFFS, 32'h0, err);
    end_test("boot_mode");
  endtask

  task automatic rtc_interval(output int cycles);
    logic start;
    start  = rtc_o;
    cycles = 0;
    do begin
      @(negedge soc_clk);
      cycles++;
    end while (rtc_o == start && cycles < 1000);
  endtask

  task automatic measure_rtc_divider();
    int   cycles;
    int   half;
    logic err;
    for (int i = 0; i < 3; i++) begin
      half = rtc_half_value(i);
      apb_write(RTC_HALF_OFFS, apb_data_t'(half), err);
      // First interval may still run on the old count
      rtc_interval(cycles);
      repeat (2) begin
        rtc_interval(cycles);
        check_value($sformatf("rtc_o interval (RTC_HALF %0d)", half), half + 1, cycles);
      end
    end
    apb_write(RTC_HALF_OFFS, 32'd24, err);
    end_test("rtc_divider");
  endtask

  task automatic count_fan_high(input fan_level_t level, input string src);
    int high;
    high = 0;
    // Let the new level reach a period boundary first
    repeat (2 * PWM_PERIOD) @(negedge soc_clk);
    repeat (PWM_PERIOD) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        high++;
      end
    end
    check_value($sformatf("fan_pwm_o high cycles (%s level %0d)", src, level),
                level * FAN_PRESCALE, high);
  endtask

  task automatic check_fan_pwm();
    fan_level_t lvl;
    logic       err;
    repeat (2) begin
      lvl = fan_level_t'($urandom_range(15));
      set_switches(boot_mode_i, lvl);
      count_fan_high(lvl, "switch");
    end
    for (int i = 0; i < 3; i++) begin
      lvl = (i == 0) ? 4'd0 : ((i == 1) ? 4'd15 : 4'd9);
      set_switches(boot_mode_i, fan_level_t'($urandom_range(15)));
      apb_write(FAN_OFFS, 32'h10 | apb_data_t'(lvl), err);
      count_fan_high(lvl, "override");
    end
    apb_write(FAN_OFFS, 32'h0, err);
    end_test("fan_pwm");
  endtask

  task automatic check_soft_reset();
    int   low_cycles;
    logic err;
    @(negedge soc_clk);
    check_value("soc_rst_n_o", 1, soc_rst_n_o);
    apb_write(CTRL_OFFS, 32'h1, err);
    @(posedge soc_clk);
    @(negedge soc_clk);
    check_value("soc_rst_n_o", 0, soc_rst_n_o);
    repeat (20) begin
      @(negedge soc_clk);
      check_value("soc_rst_n_o", 0, soc_rst_n_o);
    end
    apb_write(CTRL_OFFS, 32'h0, err);
    low_cycles = 0;
    @(negedge soc_clk);
    while (!soc_rst_n_o && low_cycles < 4 * RST_HOLD_CYCLES) begin
      low_cycles++;
      @(negedge soc_clk);
    end
    check_value("soc_rst_n_o low cycles", RST_HOLD_CYCLES, low_cycles);
    end_test("soft_reset");
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(566));
    rst_n           = 1'b0;
    paddr_i         = '0;
    psel_i          = 1'b0;
    penable_i       = 1'b0;
    pwrite_i        = 1'b0;
    pwdata_i        = '0;
    boot_mode_i     = boot_mode_t'($urandom_range(3));
    fan_sw_i        = fan_level_t'($urandom_range(15));
    n_checks        = 0;
    n_errors        = 0;
    n_tests         = 0;
    errors_at_start = 0;
    check_reset_values();
    run_register_table();
    check_boot_mode();
    measure_rtc_divider();
    check_fan_pwm();
    check_soft_reset();
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int budget;
    budget = 10 * NUM_ENTRIES + 6 * PWM_PERIOD * FAN_WINDOWS + OTHER_CYCLES;
    for (int i = 0; i < 3; i++) begin
      budget += 4 * (rtc_half_value(i) + 1);
    end
    #(budget * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", budget);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/board_pkg.sv
hdl/board_regmap_pkg.sv
hdl/board_ctrl_regs.sv
hdl/soc_reset_seq.sv
hdl/rtc_divider.sv
hdl/fan_pwm.sv
hdl/board_ctrl_top.sv
verification/board_ctrl_tb.sv
